// File: logic/addrGen_defs.svh
`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

// memory address width, also the width of iteration counts
`define ADDR_W 10
// width of period, duty and delay counters
`define PERIOD_W 8
// memory word width
`define DATA_W 32
`define MEM_DEPTH 1024

`endif

// File: logic/addrGenPkg.sv
`include "addrGen_defs.svh"

package addrGenPkg;

   // settings for one affine loop level
   typedef struct packed {
      logic [`ADDR_W-1:0] iterations;
      logic [`PERIOD_W-1:0] period;
      logic [`PERIOD_W-1:0] duty;
      logic [`PERIOD_W-1:0] delay;
      logic [`ADDR_W-1:0] start;
      logic signed [`ADDR_W-1:0] shift;
      logic signed [`ADDR_W-1:0] incr;
   } loopCfg;

   // full run, the outer level borrows delay and start from the inner one
   typedef struct packed {
      loopCfg inner;
      logic [`ADDR_W-1:0] outerIterations;
      logic [`PERIOD_W-1:0] outerPeriod;
      logic signed [`ADDR_W-1:0] outerShift;
      logic signed [`ADDR_W-1:0] outerIncr;
   } nestCfg;

   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic memEn;
   } addrBeat;

   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic valid;
   } readBeat;

endpackage

// File: logic/addrGen.sv
`timescale 1ns/1ps
`include "addrGen_defs.svh"

module addrGen (
   input  logic clk,
   input  logic rst,
   input  logic init,
   input  logic run,
   input  logic pause,
   input  addrGenPkg::loopCfg cfg,
   output addrGenPkg::addrBeat beat,
   output logic done
);

   // control state
   logic active;
   logic doneReg;
   logic [`PERIOD_W-1:0] delayCnt;
   logic [`PERIOD_W-1:0] perCnt;
   logic [`ADDR_W-1:0] iterCnt;
   logic [`ADDR_W-1:0] addrReg;

   // next-state helpers
   logic [`PERIOD_W:0] perNext;
   logic [`ADDR_W:0] iterNext;
   logic delayDone;
   logic enable;
   logic periodEnd;
   logic lastIter;
   logic [`ADDR_W-1:0] stepAddr;
   logic [`ADDR_W-1:0] nextAddr;

   assign delayDone = (delayCnt == '0);

   // one bit wider so a period or iteration count of zero ends at once
   assign perNext = {1'b0, perCnt} + 1'b1;
   assign iterNext = {1'b0, iterCnt} + 1'b1;
   assign periodEnd = (perNext >= {1'b0, cfg.period});
   assign lastIter = (iterNext >= {1'b0, cfg.iterations});

   // enabled during the first duty cycles of each period
   assign enable = active & ~pause & delayDone & (perCnt < cfg.duty);

   // incr after every enabled cycle, shift on top at the end of a period
   assign stepAddr = enable ? addrReg + cfg.incr : addrReg;
   assign nextAddr = periodEnd ? stepAddr + cfg.shift : stepAddr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active <= 1'b0;
         doneReg <= 1'b1;
         delayCnt <= '0;
         perCnt <= '0;
         iterCnt <= '0;
         addrReg <= '0;
      end else if (init) begin
         // done drops for at least one cycle, even when run stays low
         active <= run;
         doneReg <= 1'b0;
         delayCnt <= cfg.delay;
         perCnt <= '0;
         iterCnt <= '0;
         addrReg <= cfg.start;
      end else if (active & ~pause) begin
         if (!delayDone) begin
            delayCnt <= delayCnt - 1'b1;
         end else begin
            addrReg <= nextAddr;
            if (periodEnd) begin
               perCnt <= '0;
               iterCnt <= iterCnt + 1'b1;
               // last period over, done shows on the next cycle
               if (lastIter) begin
                  active <= 1'b0;
                  doneReg <= 1'b1;
               end
            end else begin
               perCnt <= perNext[`PERIOD_W-1:0];
            end
         end
      end else if (!active) begin
         // init without run, nothing to issue
         doneReg <= 1'b1;
      end
   end

   assign beat = '{addr: addrReg, memEn: enable};
   assign done = doneReg;

endmodule

// File: logic/addrGen2.sv
`timescale 1ns/1ps

module addrGen2 (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  addrGenPkg::nestCfg cfg,
   output addrGenPkg::addrBeat beat,
   output logic done
);

   addrGenPkg::loopCfg innerCfg;
   addrGenPkg::loopCfg outerCfg;
   addrGenPkg::addrBeat outerBeat;
   logic innerDone;
   logic outerDone;
   logic innerReady;
   logic outerReady;
   logic innerInit;
   logic innerRun;
   logic innerEnQ;
   logic outerPause;

   // a level with zero iterations issues nothing
   assign innerReady = |cfg.inner.iterations;
   assign outerReady = |cfg.outerIterations;

   // every outer beat restarts the inner pass from the outer address
   assign innerInit = run | outerBeat.memEn;
   // with an outer loop the first pass waits for the first outer beat
   assign innerRun = innerReady & (outerBeat.memEn | (run & ~outerReady));

   // outer loop holds through the inner pass and until its last beat has aged a cycle
   assign outerPause = ~innerDone | innerEnQ;

   assign done = innerDone & (outerDone | ~outerReady);

   always_comb begin
      innerCfg = cfg.inner;
      innerCfg.start = run ? cfg.inner.start : outerBeat.addr;
   end

   // outer level, enabled on every step of its period
   always_comb begin
      outerCfg = cfg.inner;
      outerCfg.iterations = cfg.outerIterations;
      outerCfg.period = cfg.outerPeriod;
      outerCfg.duty = cfg.outerPeriod;
      outerCfg.shift = cfg.outerShift;
      outerCfg.incr = cfg.outerIncr;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         innerEnQ <= 1'b0;
      end else begin
         innerEnQ <= beat.memEn;
      end
   end

   addrGen genInner (
      .clk   (clk),
      .rst   (rst),
      .init  (innerInit),
      .run   (innerRun),
      .pause (1'b0),
      .cfg   (innerCfg),
      .beat  (beat),
      .done  (innerDone)
   );

   addrGen genOuter (
      .clk   (clk),
      .rst   (rst),
      .init  (run),
      .run   (run & outerReady),
      .pause (outerPause),
      .cfg   (outerCfg),
      .beat  (outerBeat),
      .done  (outerDone)
   );

endmodule

// File: logic/dataMem.sv
`timescale 1ns/1ps
`include "addrGen_defs.svh"

module dataMem (
   input  logic clk,
   input  logic rst,
   input  logic wrEn,
   input  logic [`ADDR_W-1:0] wrAddr,
   input  logic [`DATA_W-1:0] wrData,
   input  addrGenPkg::addrBeat beat,
   output addrGenPkg::readBeat rdData
);

   logic [`DATA_W-1:0] mem [`MEM_DEPTH];
   logic [`DATA_W-1:0] rdWord;
   logic rdValid;

   // write port only used for loading between runs
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
      if (beat.memEn) begin
         rdWord <= mem[beat.addr];
      end
   end

   // valid lines up with the registered word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdValid <= 1'b0;
      end else begin
         rdValid <= beat.memEn;
      end
   end

   assign rdData = '{data: rdWord, valid: rdValid};

endmodule

// File: logic/addrGenTop.sv
`timescale 1ns/1ps
`include "addrGen_defs.svh"

module addrGenTop (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  logic wrEn,
   input  logic [`ADDR_W-1:0] wrAddr,
   input  logic [`DATA_W-1:0] wrData,
   input  addrGenPkg::nestCfg cfg,
   output addrGenPkg::addrBeat beat,
   output addrGenPkg::readBeat rdData,
   output logic done
);

   // generator output also goes out for observation
   addrGen2 gen (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfg  (cfg),
      .beat (beat),
      .done (done)
   );

   dataMem mem (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .beat   (beat),
      .rdData (rdData)
   );

endmodule

// File: verif/addrGenTb_assert.sv
`timescale 1ns/1ps

module addrGenAssert (
   input logic clk,
   input logic rst,
   input logic run,
   input addrGenPkg::addrBeat beat,
   input addrGenPkg::readBeat rdData,
   input logic done
);

   // an idle generator issues nothing, the run cycle aside
   enableWhileIdle: assert property (@(posedge clk) disable iff (rst)
      done && !run |-> !beat.memEn)
      else $error("memory enable seen while done is high");

   // done drops right after run
   doneDropsOnRun: assert property (@(posedge clk) disable iff (rst)
      run |=> !done)
      else $error("done still high one cycle after run");

   // only a run pulse may take done low
   doneHoldsWhileIdle: assert property (@(posedge clk) disable iff (rst)
      done && !run |=> done)
      else $error("done fell without a run pulse");

   noReadAfterDone: assert property (@(posedge clk) disable iff (rst)
      done && !run |=> !rdData.valid)
      else $error("read valid after done");

endmodule

bind addrGenTop addrGenAssert checks (
   .clk    (clk),
   .rst    (rst),
   .run    (run),
   .beat   (beat),
   .rdData (rdData),
   .done   (done)
);

// File: verif/addrGenTb.sv
`timescale 1ns/1ps
`include "addrGen_defs.svh"

module addrGenTb;

   localparam int NAME_W = 8 * 16;

   logic clk = 1'b0;
   logic rst;
   logic run;
   logic wrEn;
   logic [`ADDR_W-1:0] wrAddr;
   logic [`DATA_W-1:0] wrData;
   addrGenPkg::nestCfg cfg;
   addrGenPkg::addrBeat beat;
   addrGenPkg::readBeat rdData;
   logic done;

   // one entry per trace line
   addrGenPkg::nestCfg cfgList[$];
   logic [NAME_W-1:0] nameList[$];
   logic [`DATA_W-1:0] patList[$];

   // addresses still to be issued, and addresses whose read is still due
   int addrQ[$];
   int readQ[$];
   int watchCycles = 0;
   integer seed = 32'h5bba95ec;

   addrGenTop dut (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .cfg    (cfg),
      .beat   (beat),
      .rdData (rdData),
      .done   (done)
   );

   always #50 clk = ~clk;

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic checkAddr(input logic [NAME_W-1:0] name, input addrGenPkg::addrBeat expBeat,
                            input addrGenPkg::addrBeat actBeat);
      if (actBeat !== expBeat) begin
         abortRun($sformatf("MISMATCH %0s addr expected %0d en %0b actual %0d en %0b", name,
                            expBeat.addr, expBeat.memEn, actBeat.addr, actBeat.memEn));
      end
   endtask

   task automatic checkRead(input logic [NAME_W-1:0] name, input addrGenPkg::readBeat expRead,
                            input addrGenPkg::readBeat actRead);
      if (actRead !== expRead) begin
         abortRun($sformatf("MISMATCH %0s read expected %h valid %0b actual %h valid %0b", name,
                            expRead.data, expRead.valid, actRead.data, actRead.valid));
      end
   endtask

   task automatic readTrace();
      int fd;
      int n;
      int f[12];
      string line;
      logic [NAME_W-1:0] name;
      logic [`DATA_W-1:0] pat;
      addrGenPkg::nestCfg c;
      fd = $fopen("verif/addrGen_trace.txt", "r");
      if (fd == 0) begin
         abortRun("cannot open trace file verif/addrGen_trace.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // comment and blank lines do not yield all 13 fields
         n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %h", name, f[0], f[1], f[2],
                     f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], pat);
         if (n == 13) begin
            c.inner.iterations = `ADDR_W'(f[0]);
            c.inner.period = `PERIOD_W'(f[1]);
            c.inner.duty = `PERIOD_W'(f[2]);
            c.inner.delay = `PERIOD_W'(f[3]);
            c.inner.start = `ADDR_W'(f[4]);
            c.inner.shift = `ADDR_W'(f[5]);
            c.inner.incr = `ADDR_W'(f[6]);
            c.outerIterations = `ADDR_W'(f[7]);
            c.outerPeriod = `PERIOD_W'(f[8]);
            c.outerShift = `ADDR_W'(f[9]);
            c.outerIncr = `ADDR_W'(f[10]);
            cfgList.push_back(c);
            nameList.push_back(name);
            patList.push_back(pat);
         end
      end
      $fclose(fd);
      if (cfgList.size() == 0) begin
         abortRun("trace file holds no test");
      end
   endtask

   // load, longest gap and the run itself with some slack per outer step
   function automatic int worstCycles(input addrGenPkg::nestCfg c);
      int pass;
      int total;
      pass = int'(c.inner.delay) + int'(c.inner.iterations) * int'(c.inner.period) + 4;
      total = pass;
      if (c.outerIterations != 0) begin
         total = int'(c.inner.delay) + 4
                 + int'(c.outerIterations) * int'(c.outerPeriod) * (pass + 4);
      end
      return total + `MEM_DEPTH + 16;
   endfunction

   // outer bases first, then the inner pattern replayed from each base
   task automatic buildExpected(input addrGenPkg::nestCfg c);
      int bases[$];
      int incr;
      int shift;
      int duty;
      incr = $signed(c.inner.incr);
      shift = $signed(c.inner.shift);
      duty = int'(c.inner.duty);
      addrQ.delete();
      readQ.delete();
      if (c.outerIterations == 0) begin
         bases.push_back(int'(c.inner.start));
      end else begin
         for (int k = 0; k < int'(c.outerIterations) * int'(c.outerPeriod); k++) begin
            bases.push_back(int'(c.inner.start) + k * $signed(c.outerIncr)
                            + (k / int'(c.outerPeriod)) * $signed(c.outerShift));
         end
      end
      if (c.inner.iterations != 0) begin
         foreach (bases[b]) begin
            for (int i = 0; i < int'(c.inner.iterations); i++) begin
               for (int j = 0; j < duty; j++) begin
                  addrQ.push_back((bases[b] + (i * duty + j) * incr + i * shift)
                                  & (`MEM_DEPTH - 1));
               end
            end
         end
      end
   endtask

   task automatic runTest(input int t);
      addrGenPkg::nestCfg c;
      addrGenPkg::addrBeat expBeat;
      addrGenPkg::readBeat expRead;
      logic [NAME_W-1:0] name;
      logic [`DATA_W-1:0] pat;
      int total;
      int reads;
      int cycle;
      int gap;
      int a;
      c = cfgList[t];
      name = nameList[t];
      pat = patList[t];
      for (a = 0; a < `MEM_DEPTH; a++) begin
         @(negedge clk);
         wrEn = 1'b1;
         wrAddr = `ADDR_W'(a);
         wrData = `DATA_W'(a) ^ pat;
      end
      @(negedge clk);
      wrEn = 1'b0;
      buildExpected(c);
      total = addrQ.size();
      reads = 0;
      cycle = 0;
      cfg = c;
      run = 1'b1;
      do begin
         @(negedge clk);
         run = 1'b0;
         cycle++;
         if (cycle == 1 && done) begin
            abortRun($sformatf("test %0s: done did not drop after run", name));
         end
         // the older address is retired first
         if (rdData.valid) begin
            if (readQ.size() == 0) begin
               abortRun($sformatf("test %0s: read valid with no address issued", name));
            end
            a = readQ.pop_front();
            expRead.data = `DATA_W'(a) ^ pat;
            expRead.valid = 1'b1;
            checkRead(name, expRead, rdData);
            reads++;
         end
         if (beat.memEn) begin
            if (addrQ.size() == 0) begin
               abortRun($sformatf("test %0s: more addresses than expected", name));
            end
            a = addrQ.pop_front();
            expBeat.addr = `ADDR_W'(a);
            expBeat.memEn = 1'b1;
            checkAddr(name, expBeat, beat);
            readQ.push_back(a);
         end
      end while (!done);
      if (reads != total || addrQ.size() != 0 || readQ.size() != 0) begin
         abortRun($sformatf("test %0s: done after %0d of %0d reads", name, reads, total));
      end
      gap = 2 + ($random(seed) & 7);
      repeat (gap) begin
         @(negedge clk);
         if (rdData.valid || beat.memEn || !done) begin
            abortRun($sformatf("test %0s: activity or done low after the run ended", name));
         end
      end
   endtask

   initial begin
      addrGenPkg::addrBeat idleBeat;
      rst = 1'b1;
      run = 1'b0;
      wrEn = 1'b0;
      wrAddr = '0;
      wrData = '0;
      cfg = '0;
      readTrace();
      foreach (cfgList[t]) begin
         watchCycles += worstCycles(cfgList[t]);
      end
      watchCycles = watchCycles * 2 + 64;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      idleBeat = '0;
      checkAddr("reset", idleBeat, beat);
      if (!done || rdData.valid) begin
         abortRun("after reset done is not high or read valid is not low");
      end
      foreach (cfgList[t]) begin
         runTest(t);
      end
      $display("Regression passed");
      $finish;
   end

   // limit comes from the summed worst case of all trace lines
   initial begin
      wait (watchCycles > 0);
      repeat (watchCycles) @(posedge clk);
      abortRun($sformatf("timeout, tests did not finish within %0d cycles", watchCycles));
   end

endmodule

// File: verif/addrGen_trace.txt
# name iterations period duty delay start shift incr outerIterations outerPeriod outerShift outerIncr pattern
# all decimal except the hex pattern; shift and incr are signed; memory word = addr ^ pattern
singleLoop  3  4 4 0   10   0  1 0 0    0   0 a5a50000
dutyGap     4  6 2 3  100   5  2 0 0    0   0 0f0f0f0f
nestTwo     2  3 2 1    0  10  1 3 2   64  16 12345678
negWrap     3  4 3 0    5  -7 -2 0 0    0   0 deadbeef
negNest     2  2 2 2 1000   3  1 2 3 -100  50 00ff00ff
innerZero   0  4 2 0   50   1  1 0 0    0   0 cafe0000
zeroNested  0  3 3 1   20   0  1 3 2   10   5 0000cafe
longRun    20  5 5 4  512  -1  3 0 0    0   0 13579bdf
oneShot     1  1 1 0 1023   0  0 4 1    0   1 fedcba98
denseNest   4  2 2 0  300   0  1 2 2  100   8 76543210
sparseNest  3  5 1 2  700 -20  4 2 3   -9 -30 aaaa5555

// File: verilog.f
+incdir+logic
logic/addrGenPkg.sv
logic/addrGen.sv
logic/addrGen2.sv
logic/dataMem.sv
logic/addrGenTop.sv
verif/addrGenTb_assert.sv
verif/addrGenTb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module addrGenTb -f verilog.f -o simAddrGen

./obj_dir/simAddrGen 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
grep -q "Regression passed" sim.log
